// File: design/armPipe_macros.svh
`ifndef ARMPIPE_MACROS_SVH
`define ARMPIPE_MACROS_SVH

// Datapath widths
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 4

// Fetch address step per instruction
`define PC_STEP 4

// R15 reads as the instruction address plus this
`define PC_READ_OFFSET 8

`define RESET_PC 0   // First fetch address
`define PC_REG 15    // Register number of the PC

`endif

// File: design/armPipePkg.sv
`include "armPipe_macros.svh"

package armPipePkg;

  // One register word, also used for addresses
  typedef logic [`DATA_WIDTH-1:0] word_t;

  typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;  // Register number

  // ALU operations decoded from cmd
  typedef enum logic [1:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr
  } aluOp_t;

  // Operand source in execute
  typedef enum logic [1:0] {
    fwdNone,  // Value read in decode
    fwdWb,    // Writeback result
    fwdMem    // Memory-slot result, youngest
  } fwdSel_t;

endpackage

// File: design/fetchStage.sv
`timescale 1ns/1ns
`include "armPipe_macros.svh"

module fetchStage (
  input  logic              clk,
  input  logic              arstN,
  input  logic              wbAck,
  input  armPipePkg::word_t wbDatIn,
  output logic              wbCyc,
  output logic              wbStb,
  output armPipePkg::word_t wbAdr,
  output armPipePkg::word_t instrD,
  output armPipePkg::word_t pcPlus8D,
  output logic              validD
);

  armPipePkg::word_t pc;  // Address of the pending fetch
  logic reqOn;            // Low in the first cycle after reset
  logic accept;           // Instruction transferred at this edge

  // Classic read cycle with one request at a time
  assign wbCyc  = reqOn;
  assign wbStb  = reqOn;
  assign wbAdr  = pc;  // Held until ack
  assign accept = reqOn & wbAck;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      reqOn  <= 1'b0;
      pc     <= armPipePkg::word_t'(`RESET_PC);
      instrD <= '0;
      validD <= 1'b0;
    end else begin
      reqOn  <= 1'b1;                   // Fetch continuously
      validD <= accept;
      instrD <= accept ? wbDatIn : '0;  // Bubble on a wait cycle
      if (accept) begin
        pc <= pc + armPipePkg::word_t'(`PC_STEP);
      end
    end
  end

  // R15 value seen by the instruction now in decode
  always_ff @(posedge clk) begin
    if (accept) begin
      pcPlus8D <= pc + armPipePkg::word_t'(`PC_READ_OFFSET);
    end
  end

  // Slave acks only a pending request
  ackNeedsStb: assert property (@(posedge clk) disable iff (!arstN)
    wbAck |-> wbStb)
    else $error("wbAck without a pending request");

  // Fetched word must be driven on the accepting edge
  datKnownOnAck: assert property (@(posedge clk) disable iff (!arstN)
    accept |-> !$isunknown(wbDatIn))
    else $error("wbDatIn unknown at ack");

endmodule

// File: design/regFile.sv
`timescale 1ns/1ns
`include "armPipe_macros.svh"

module regFile (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 we,
  input  armPipePkg::regAddr_t wa,
  input  armPipePkg::word_t    wd,
  input  armPipePkg::regAddr_t ra1,
  input  armPipePkg::regAddr_t ra2,
  input  armPipePkg::word_t    r15,
  output armPipePkg::word_t    rd1,
  output armPipePkg::word_t    rd2
);

  localparam int NumRegs = 1 << `REG_ADDR_WIDTH;
  localparam armPipePkg::regAddr_t PcReg = `PC_REG;

  armPipePkg::word_t regs [NumRegs];  // Entry 15 is never read

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;  // End of the writeback cycle
    end
  end

  // PC first, then write-through, then the array
  assign rd1 = (ra1 == PcReg) ? r15 : (we && ra1 == wa) ? wd : regs[ra1];
  assign rd2 = (ra2 == PcReg) ? r15 : (we && ra2 == wa) ? wd : regs[ra2];

  // Decode must have dropped every write to the PC
  noPcWrite: assert property (@(posedge clk) disable iff (!arstN)
    we |-> (wa != PcReg))
    else $error("Register write to R15 reached writeback");

endmodule

// File: design/decodeStage.sv
`timescale 1ns/1ns
`include "armPipe_macros.svh"

module decodeStage (
  input  logic                 clk,
  input  logic                 arstN,
  input  armPipePkg::word_t    instrD,
  input  armPipePkg::word_t    pcPlus8D,
  input  logic                 validD,
  input  logic                 writeW,
  input  armPipePkg::regAddr_t rdW,
  input  armPipePkg::word_t    resultW,
  output armPipePkg::word_t    rnValE,
  output armPipePkg::word_t    rmValE,
  output armPipePkg::word_t    immE,
  output armPipePkg::aluOp_t   aluOpE,
  output logic                 useImmE,
  output logic                 writeE,
  output armPipePkg::regAddr_t rdE,
  output armPipePkg::regAddr_t srcAE,
  output armPipePkg::regAddr_t srcBE
);

  localparam armPipePkg::regAddr_t PcReg = `PC_REG;

  armPipePkg::regAddr_t rnD;
  armPipePkg::regAddr_t rdD;
  armPipePkg::regAddr_t rmD;
  armPipePkg::word_t    rnValD;
  armPipePkg::word_t    rmValD;
  armPipePkg::word_t    immD;
  armPipePkg::aluOp_t   aluOpD;
  logic                 cmdKnown;
  logic                 writeD;
  logic [4:0]           rotAmt;
  logic [2*`DATA_WIDTH-1:0] immPair;  // imm8 doubled for the rotate

  assign rnD = instrD[19:16];
  assign rdD = instrD[15:12];
  assign rmD = instrD[3:0];

  // imm8 rotated right by twice the rotate field
  assign rotAmt  = {instrD[11:8], 1'b0};
  assign immPair = {2{armPipePkg::word_t'(instrD[7:0])}} >> rotAmt;
  assign immD    = immPair[`DATA_WIDTH-1:0];

  always_comb begin
    cmdKnown = 1'b1;
    aluOpD   = armPipePkg::aluAdd;
    case (instrD[24:21])
      4'b0100: aluOpD = armPipePkg::aluAdd;
      4'b0010: aluOpD = armPipePkg::aluSub;
      4'b0000: aluOpD = armPipePkg::aluAnd;
      4'b1100: aluOpD = armPipePkg::aluOrr;
      default: cmdKnown = 1'b0;  // Not in the subset
    endcase
  end

  // Data processing only, R15 as destination is a no-op
  assign writeD = validD && (instrD[27:26] == 2'b00) && cmdKnown && (rdD != PcReg);

  regFile i_regFile (
    .clk  (clk),
    .arstN(arstN),
    .we   (writeW),
    .wa   (rdW),
    .wd   (resultW),
    .ra1  (rnD),
    .ra2  (rmD),
    .r15  (pcPlus8D),
    .rd1  (rnValD),
    .rd2  (rmValD)
  );

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      writeE <= 1'b0;
    end else begin
      writeE <= writeD;  // Bubbles carry no write
    end
  end

  always_ff @(posedge clk) begin
    rnValE  <= rnValD;
    rmValE  <= rmValD;
    immE    <= immD;
    aluOpE  <= aluOpD;
    useImmE <= instrD[25];  // I bit
    rdE     <= rdD;
    srcAE   <= rnD;
    srcBE   <= rmD;
  end

endmodule

// File: design/forwardUnit.sv
`timescale 1ns/1ns
`include "armPipe_macros.svh"

module forwardUnit (
  input  armPipePkg::regAddr_t srcAE,
  input  armPipePkg::regAddr_t srcBE,
  input  armPipePkg::regAddr_t rdM,
  input  armPipePkg::regAddr_t rdW,
  input  logic                 writeM,
  input  logic                 writeW,
  output armPipePkg::fwdSel_t  fwdAE,
  output armPipePkg::fwdSel_t  fwdBE
);

  localparam armPipePkg::regAddr_t PcReg = `PC_REG;

  // Younger memory-slot result wins over writeback
  function automatic armPipePkg::fwdSel_t pickSrc(
    input armPipePkg::regAddr_t src,
    input armPipePkg::regAddr_t dstM,
    input logic                 wrM,
    input armPipePkg::regAddr_t dstW,
    input logic                 wrW
  );
    if (src == PcReg) return armPipePkg::fwdNone;  // PC is never produced here
    if (wrM && dstM == src) return armPipePkg::fwdMem;
    if (wrW && dstW == src) return armPipePkg::fwdWb;
    return armPipePkg::fwdNone;
  endfunction

  assign fwdAE = pickSrc(srcAE, rdM, writeM, rdW, writeW);
  assign fwdBE = pickSrc(srcBE, rdM, writeM, rdW, writeW);

endmodule

// File: design/executeStage.sv
`timescale 1ns/1ns

module executeStage (
  input  logic                 clk,
  input  logic                 arstN,
  input  armPipePkg::word_t    rnValE,
  input  armPipePkg::word_t    rmValE,
  input  armPipePkg::word_t    immE,
  input  armPipePkg::aluOp_t   aluOpE,
  input  logic                 useImmE,
  input  logic                 writeE,
  input  armPipePkg::regAddr_t rdE,
  input  armPipePkg::fwdSel_t  fwdAE,
  input  armPipePkg::fwdSel_t  fwdBE,
  output armPipePkg::word_t    resultM,
  output armPipePkg::regAddr_t rdM,
  output logic                 writeM,
  output armPipePkg::word_t    resultW,
  output armPipePkg::regAddr_t rdW,
  output logic                 writeW
);

  armPipePkg::word_t srcA;
  armPipePkg::word_t rmFwd;   // Operand B before the immediate mux
  armPipePkg::word_t srcB;
  armPipePkg::word_t aluResult;

  // Bypass mux shared by both operands
  function automatic armPipePkg::word_t fwdMux(
    input armPipePkg::fwdSel_t sel,
    input armPipePkg::word_t   regVal,
    input armPipePkg::word_t   memVal,
    input armPipePkg::word_t   wbVal
  );
    case (sel)
      armPipePkg::fwdMem: return memVal;
      armPipePkg::fwdWb:  return wbVal;
      default:            return regVal;
    endcase
  endfunction

  assign srcA  = fwdMux(fwdAE, rnValE, resultM, resultW);
  assign rmFwd = fwdMux(fwdBE, rmValE, resultM, resultW);
  assign srcB  = useImmE ? immE : rmFwd;

  always_comb begin
    case (aluOpE)
      armPipePkg::aluAdd: aluResult = srcA + srcB;
      armPipePkg::aluSub: aluResult = srcA - srcB;
      armPipePkg::aluAnd: aluResult = srcA & srcB;
      default:            aluResult = srcA | srcB;  // ORR
    endcase
  end

  // Write flags, memory slot then writeback
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      writeM <= 1'b0;
      writeW <= 1'b0;
    end else begin
      writeM <= writeE;
      writeW <= writeM;
    end
  end

  always_ff @(posedge clk) begin
    resultM <= aluResult;
    rdM     <= rdE;
    resultW <= resultM;  // No memory access in this slot
    rdW     <= rdM;
  end

endmodule

// File: design/armPipe.sv
`timescale 1ns/1ns

module armPipe (
  input  logic                 clk,
  input  logic                 arstN,
  output logic                 wbCyc,
  output logic                 wbStb,
  output armPipePkg::word_t    wbAdr,
  input  logic                 wbAck,
  input  armPipePkg::word_t    wbDatIn,
  output logic                 retValid,
  output armPipePkg::regAddr_t retReg,
  output armPipePkg::word_t    retData
);

  // Fetch to decode
  armPipePkg::word_t    instrD;
  armPipePkg::word_t    pcPlus8D;
  logic                 validD;
  // Decode to execute
  armPipePkg::word_t    rnValE;
  armPipePkg::word_t    rmValE;
  armPipePkg::word_t    immE;
  armPipePkg::aluOp_t   aluOpE;
  logic                 useImmE;
  logic                 writeE;
  armPipePkg::regAddr_t rdE;
  armPipePkg::regAddr_t srcAE;
  armPipePkg::regAddr_t srcBE;
  // Memory slot and writeback
  armPipePkg::word_t    resultM;
  armPipePkg::regAddr_t rdM;
  logic                 writeM;
  armPipePkg::word_t    resultW;
  armPipePkg::regAddr_t rdW;
  logic                 writeW;
  armPipePkg::fwdSel_t  fwdAE;
  armPipePkg::fwdSel_t  fwdBE;

  fetchStage i_fetchStage (
    .clk(clk), .arstN(arstN), .wbAck(wbAck), .wbDatIn(wbDatIn),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
    .instrD(instrD), .pcPlus8D(pcPlus8D), .validD(validD)
  );

  decodeStage i_decodeStage (
    .clk(clk), .arstN(arstN), .instrD(instrD), .pcPlus8D(pcPlus8D), .validD(validD),
    .writeW(writeW), .rdW(rdW), .resultW(resultW),
    .rnValE(rnValE), .rmValE(rmValE), .immE(immE), .aluOpE(aluOpE), .useImmE(useImmE),
    .writeE(writeE), .rdE(rdE), .srcAE(srcAE), .srcBE(srcBE)
  );

  forwardUnit i_forwardUnit (
    .srcAE(srcAE), .srcBE(srcBE), .rdM(rdM), .rdW(rdW),
    .writeM(writeM), .writeW(writeW), .fwdAE(fwdAE), .fwdBE(fwdBE)
  );

  executeStage i_executeStage (
    .clk(clk), .arstN(arstN), .rnValE(rnValE), .rmValE(rmValE), .immE(immE),
    .aluOpE(aluOpE), .useImmE(useImmE), .writeE(writeE), .rdE(rdE),
    .fwdAE(fwdAE), .fwdBE(fwdBE),
    .resultM(resultM), .rdM(rdM), .writeM(writeM),
    .resultW(resultW), .rdW(rdW), .writeW(writeW)
  );

  // Register write taking place this cycle
  assign retValid = writeW;
  assign retReg   = rdW;
  assign retData  = resultW;

endmodule

// File: sim/armPipeModel.svh
`ifndef ARMPIPE_MODEL_SVH
`define ARMPIPE_MODEL_SVH

// In-order reference, one instruction per fetch
armPipePkg::word_t    modelRegs [16];
armPipePkg::regAddr_t expReg [$];   // Expected retires, oldest first
armPipePkg::word_t    expData [$];
int                   expEdge [$];  // Clock edge where each retire becomes visible
int                   modelWrites;

task automatic resetModel();
  for (int i = 0; i < 16; i++) begin
    modelRegs[i] = '0;
  end
  modelWrites = 0;
endtask

// 8-bit immediate, rotated right by twice the rotate field
function automatic armPipePkg::word_t rotateImm(input armPipePkg::word_t instr);
  armPipePkg::word_t imm8;
  int amt;
  imm8 = {24'd0, instr[7:0]};
  amt  = 2 * instr[11:8];
  return (imm8 >> amt) | (imm8 << (32 - amt));  // Shift by 32 yields zero
endfunction

function automatic armPipePkg::word_t readModelReg(input logic [3:0] r,
                                                  input armPipePkg::word_t addr);
  return (r == `PC_REG) ? addr + `PC_READ_OFFSET : modelRegs[r];
endfunction

task automatic executeModel(input armPipePkg::word_t instr, input armPipePkg::word_t addr,
                            input int retireEdge);
  armPipePkg::word_t a;
  armPipePkg::word_t b;
  armPipePkg::word_t res;
  logic              known;
  logic [3:0]        rd;
  known = 1'b1;
  rd    = instr[15:12];
  a     = readModelReg(instr[19:16], addr);
  b     = instr[25] ? rotateImm(instr) : readModelReg(instr[3:0], addr);
  case (instr[24:21])
    4'b0100: res = a + b;  // ADD
    4'b0010: res = a - b;  // SUB
    4'b0000: res = a & b;  // AND
    4'b1100: res = a | b;  // ORR
    default: begin
      res   = '0;
      known = 1'b0;
    end
  endcase
  // Condition and S bit play no part
  if (instr[27:26] == 2'b00 && known && rd != `PC_REG) begin
    modelRegs[rd] = res;
    expReg.push_back(rd);
    expData.push_back(res);
    expEdge.push_back(retireEdge);
    modelWrites++;
  end
endtask

`endif

// File: sim/armPipeTb.sv
`timescale 1ns/1ns
`include "armPipe_macros.svh"

module armPipeTb;

  localparam int ProgLen       = 200;
  localparam int ZeroWaitCount = 50;  // Back-to-back fetches first
  localparam int ClkPeriod     = 20;
  localparam int ResetCycles   = 2;
  localparam int DrainCycles   = 8;
  localparam int WatchdogTime  = (ProgLen * 5 + 100) * ClkPeriod;

  logic                 clk = 1'b0;
  logic                 arstN;
  logic                 wbCyc;
  logic                 wbStb;
  armPipePkg::word_t    wbAdr;
  logic                 wbAck;
  armPipePkg::word_t    wbDatIn;
  logic                 retValid;
  armPipePkg::regAddr_t retReg;
  armPipePkg::word_t    retData;

  armPipePkg::word_t prog [ProgLen];
  armPipePkg::word_t nextAdr;  // Address the next accept must carry
  armPipePkg::word_t heldAdr;
  int   edgeCnt = 0;
  int   nAccepted;
  int   waitLeft;              // Wait cycles before the next ack
  int   drain;
  int   retires;
  int   idx;
  logic waiting;               // Last cycle had a request without ack

  `include "armPipeModel.svh"

  armPipe i_armPipe (
    .clk(clk), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
    .wbAck(wbAck), .wbDatIn(wbDatIn),
    .retValid(retValid), .retReg(retReg), .retData(retData)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  always @(posedge clk) edgeCnt <= edgeCnt + 1;  // Read on the falling edge

  task automatic stopOnError(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkIdle(input string phase);
    assert (!wbCyc && !wbStb && !retValid)
      else stopOnError($sformatf("wbCyc, wbStb or retValid high during %s", phase));
  endtask

  // Mostly R0-R3 data processing, the rest never writes
  function automatic armPipePkg::word_t randomInstr();
    int          pick;
    logic [3:0]  cmd;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [1:0]  opField;
    logic        immBit;
    logic [11:0] op2;
    pick    = $urandom_range(99);
    opField = 2'b00;
    immBit  = $urandom_range(1);
    rn      = $urandom_range(3);
    rd      = $urandom_range(3);
    case ($urandom_range(3))
      0:       cmd = 4'b0100;
      1:       cmd = 4'b0010;
      2:       cmd = 4'b0000;
      default: cmd = 4'b1100;
    endcase
    op2 = immBit ? 12'($urandom()) : {8'd0, 4'($urandom_range(3))};
    if (pick < 8) rn = 4'd15;                   // Reads the PC
    if (pick < 4 && !immBit) op2[3:0] = 4'd15;
    if (pick >= 75 && pick < 85) begin
      rd = 4'd15;                               // PC write, dropped
    end else if (pick >= 85 && pick < 93) begin
      cmd = 4'($urandom_range(15)) | 4'b0001;   // Odd cmds are outside the subset
    end else if (pick >= 93) begin
      opField = 2'($urandom_range(3, 1));       // Not data processing
    end
    return {4'($urandom()), opField, immBit, cmd, 1'($urandom()), rn, rd, op2};
  endfunction

  initial begin
    waitLeft = $urandom(32'h45e);  // Seed once
    arstN    = 1'b0;
    wbAck    = 1'b0;
    wbDatIn  = '0;
    resetModel();
    for (int i = 0; i < ProgLen; i++) begin
      prog[i] = randomInstr();
    end
    nextAdr   = `RESET_PC;
    heldAdr   = '0;
    nAccepted = 0;
    waitLeft  = 0;
    drain     = 0;
    retires   = 0;
    waiting   = 1'b0;
    repeat (ResetCycles) begin
      @(negedge clk);
      checkIdle("reset");
    end
    arstN = 1'b1;
    #(ClkPeriod / 4);
    checkIdle("the first cycle after reset");
    while (nAccepted < ProgLen || drain < DrainCycles) begin
      @(negedge clk);
      if (nAccepted == ProgLen) drain++;
      assert (wbCyc === wbStb) else stopOnError("wbCyc and wbStb differ");
      if (retValid) begin
        assert (expReg.size() > 0) else stopOnError("Register write retired but none expected");
        assert (retReg != `PC_REG) else stopOnError("Write to R15 retired");
        assert (retReg == expReg[0])
          else stopOnError($sformatf("FAIL retire reg: expected R%0d actual R%0d",
                                     expReg[0], retReg));
        assert (retData == expData[0])
          else stopOnError($sformatf("FAIL retire data: expected %h actual %h",
                                     expData[0], retData));
        assert (edgeCnt == expEdge[0])
          else stopOnError($sformatf("FAIL retire timing: expected edge %0d actual edge %0d",
                                     expEdge[0], edgeCnt));
        void'(expReg.pop_front());
        void'(expData.pop_front());
        void'(expEdge.pop_front());
        retires++;
      end
      if (waiting) begin
        assert (wbStb && wbAdr == heldAdr)
          else stopOnError($sformatf("FAIL request hold: expected %h actual %h", heldAdr, wbAdr));
      end
      waiting = 1'b0;
      if (wbStb && nAccepted < ProgLen && waitLeft == 0) begin
        assert (wbAdr == nextAdr)
          else stopOnError($sformatf("FAIL fetch address: expected %h actual %h", nextAdr, wbAdr));
        idx     = wbAdr / 4;
        wbAck   = 1'b1;
        wbDatIn = prog[idx];
        executeModel(prog[idx], wbAdr, edgeCnt + 4);  // Accept edge plus three
        nextAdr   = nextAdr + `PC_STEP;
        nAccepted++;
        waitLeft  = (nAccepted < ZeroWaitCount) ? 0 : $urandom_range(3);
      end else begin
        wbAck   = 1'b0;
        wbDatIn = $urandom();  // Junk, must be ignored
        if (wbStb && nAccepted < ProgLen) waitLeft--;
        waiting = wbStb;
        heldAdr = wbAdr;
      end
    end
    assert (expReg.size() == 0)
      else stopOnError($sformatf("%0d expected register writes never retired", expReg.size()));
    assert (retires == modelWrites)
      else stopOnError($sformatf("FAIL retire count: expected %0d actual %0d",
                                 modelWrites, retires));
    $display("NO ERRORS");
    $finish;
  end

  // Bound from program length, five cycles each plus margin
  initial begin
    #(WatchdogTime);
    stopOnError($sformatf("Watchdog expired with %0d of %0d instructions fetched",
                          nAccepted, ProgLen));
  end

endmodule

// File: all.f
+incdir+design
+incdir+sim
design/armPipePkg.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/forwardUnit.sv
design/executeStage.sv
design/armPipe.sv
sim/armPipeTb.sv
